/* hdl/mem_ctl_cfg.svh */
// Sv39 only with 64-bit data and 32-bit instructions; the widths are fixed by the ISA
`ifndef MEM_CTL_CFG_SVH
`define MEM_CTL_CFG_SVH

// Data and address width
`define XLEN 64

// Instruction width, no compressed encodings
`define ILEN 32

// Sv39 virtual page number, three 9-bit levels
`define VPN_LEN 27

// 4 KiB pages
`define PAGE_OFF_LEN 12

// Width of the mcause exception code field used here
`define EXC_CODE_LEN 4

`endif

/* hdl/mem_ctl_pkg.sv */
// Types for the memory control unit; exception codes cover only the causes this unit acts on
`default_nettype none
`include "mem_ctl_cfg.svh"

package mem_ctl_pkg;

	// Major opcodes that the unit looks at
	typedef enum logic [6:0] {
		OP_LOAD     = 7'b0000011,
		OP_MISC_MEM = 7'b0001111,
		OP_STORE    = 7'b0100011,
		OP_BRANCH   = 7'b1100011,
		OP_SYSTEM   = 7'b1110011
	} opcode_e;

	// One member per funct3 value, named after the branch where one exists
	typedef enum logic [2:0] {
		F3_BEQ   = 3'b000,
		F3_BNE   = 3'b001,
		F3_LW_SW = 3'b010,
		F3_LD_SD = 3'b011,
		F3_BLT   = 3'b100,
		F3_BGE   = 3'b101,
		F3_BLTU  = 3'b110,
		F3_BGEU  = 3'b111
	} funct3_e;

	// Load/store and system names for the shared funct3 values
	localparam funct3_e F3_LB_SB   = F3_BEQ;
	localparam funct3_e F3_LH_SH   = F3_BNE;
	localparam funct3_e F3_LBU     = F3_BLT;
	localparam funct3_e F3_LHU     = F3_BGE;
	localparam funct3_e F3_LWU     = F3_BLTU;
	localparam funct3_e F3_FENCE_I = F3_BNE;
	localparam funct3_e F3_PRIV    = F3_BEQ;

	typedef enum logic [2:0] {beq, bne, blt, bltu, bge, bgeu} branch_type_e;

	typedef enum logic [2:0] {
		LS_BYTE, LS_BYTE_U, LS_HALFWORD, LS_HALFWORD_U, LS_WORD, LS_WORD_U, LS_DOUBLEWORD
	} ldst_type_e;

	// RISC-V mcause values
	typedef enum logic [`EXC_CODE_LEN-1:0] {
		E_I_ADDR_MISALIGNED   = 4'd0,
		E_I_ACCESS_FAULT      = 4'd1,
		E_ILLEGAL_INSTRUCTION = 4'd2,
		E_LD_ADDR_MISALIGNED  = 4'd4,
		E_LD_ACCESS_FAULT     = 4'd5,
		E_ST_ADDR_MISALIGNED  = 4'd6,
		E_ST_ACCESS_FAULT     = 4'd7,
		E_ENV_CALL_UMODE      = 4'd8,
		E_ENV_CALL_SMODE      = 4'd9,
		E_ENV_CALL_MMODE      = 4'd11,
		E_INSTR_PAGE_FAULT    = 4'd12,
		E_LD_PAGE_FAULT       = 4'd13,
		E_ST_PAGE_FAULT       = 4'd15
	} except_code_e;

	typedef enum logic [1:0] {NO_FLUSH, FLUSH_PAGE, FLUSH_ALL} tlb_flush_e;

	typedef enum logic [1:0] {NO_FENCE, FENCE_I, SFENCE_VMA} fence_kind_e;

	typedef enum logic [2:0] {ACT_NONE, ACT_IFAULT, ACT_DFAULT, ACT_ILLEGAL, ACT_ECALL} exc_action_e;

endpackage

`default_nettype wire

/* hdl/instr_class_decoder.sv */
// Purely combinational; SFENCE.VMA matches on funct7 only, so rs1, rs2 and rd are not checked
`timescale 1ns/1ns
`default_nettype none
`include "mem_ctl_cfg.svh"

module instr_class_decoder
	import mem_ctl_pkg::*;
(
	input  wire logic [`ILEN-1:0] instr_i,
	output branch_type_e          branch_type_o,
	output ldst_type_e            ldst_type_o,
	output fence_kind_e           fence_kind_o
);

	localparam logic [6:0] SFENCE_VMA_FUNCT7 = 7'b0001001;

	opcode_e    opcode;
	funct3_e    funct3;
	logic [6:0] funct7;

	assign opcode = opcode_e'(instr_i[6:0]);
	assign funct3 = funct3_e'(instr_i[14:12]);
	assign funct7 = instr_i[31:25];

	always_comb begin
		branch_type_o = beq;
		ldst_type_o   = LS_WORD;
		fence_kind_o  = NO_FENCE;

		case (opcode)
			OP_BRANCH: begin
				case (funct3)
					F3_BNE:  branch_type_o = bne;
					F3_BLT:  branch_type_o = blt;
					F3_BLTU: branch_type_o = bltu;
					F3_BGE:  branch_type_o = bge;
					F3_BGEU: branch_type_o = bgeu;
					default: branch_type_o = beq;
				endcase
			end
			OP_LOAD: begin
				case (funct3)
					F3_LB_SB: ldst_type_o = LS_BYTE;
					F3_LBU:   ldst_type_o = LS_BYTE_U;
					F3_LH_SH: ldst_type_o = LS_HALFWORD;
					F3_LHU:   ldst_type_o = LS_HALFWORD_U;
					F3_LWU:   ldst_type_o = LS_WORD_U;
					F3_LD_SD: ldst_type_o = LS_DOUBLEWORD;
					default:  ldst_type_o = LS_WORD;
				endcase
			end
			// Stores have no unsigned forms
			OP_STORE: begin
				case (funct3)
					F3_LB_SB: ldst_type_o = LS_BYTE;
					F3_LH_SH: ldst_type_o = LS_HALFWORD;
					F3_LD_SD: ldst_type_o = LS_DOUBLEWORD;
					default:  ldst_type_o = LS_WORD;
				endcase
			end
			OP_MISC_MEM: begin
				if (funct3 == F3_FENCE_I) begin
					fence_kind_o = FENCE_I;
				end
			end
			OP_SYSTEM: begin
				if (funct3 == F3_PRIV && funct7 == SFENCE_VMA_FUNCT7) begin
					fence_kind_o = SFENCE_VMA;
				end
			end
			default: begin
				fence_kind_o = NO_FENCE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/except_classifier.sv */
// Holds one exception at a time; a report is taken only while capture_en_i is high
`timescale 1ns/1ns
`default_nettype none
`include "mem_ctl_cfg.svh"

module except_classifier
	import mem_ctl_pkg::*;
(
	input  wire logic              clk_i,
	input  wire logic              rst_n_i,
	input  wire logic              capture_en_i,
	input  wire logic              except_raised_i,
	input  except_code_e           except_code_i,
	input  wire logic [`XLEN-1:0]  except_tval_i,
	input  wire logic              exc_ack_i,
	output logic                   exc_pending_o,
	output exc_action_e            exc_action_o,
	output logic                   exc_is_page_fault_o,
	output logic [`VPN_LEN-1:0]    exc_vpn_o
);

	logic        pending_q;
	logic        capture;
	exc_action_e action;

	assign capture = capture_en_i && except_raised_i;

	// A new report is visible in its own cycle so the FSM can leave IDLE at that edge
	assign exc_pending_o = pending_q || capture;

	always_comb begin
		case (except_code_i)
			E_I_ADDR_MISALIGNED, E_I_ACCESS_FAULT, E_INSTR_PAGE_FAULT: action = ACT_IFAULT;
			E_LD_ADDR_MISALIGNED, E_LD_ACCESS_FAULT, E_LD_PAGE_FAULT,
			E_ST_ADDR_MISALIGNED, E_ST_ACCESS_FAULT, E_ST_PAGE_FAULT: action = ACT_DFAULT;
			E_ILLEGAL_INSTRUCTION:              action = ACT_ILLEGAL;
			E_ENV_CALL_SMODE, E_ENV_CALL_MMODE: action = ACT_ECALL;
			default:                            action = ACT_NONE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pending_q <= 1'b0;
		end else if (capture) begin
			pending_q <= 1'b1;
		end else if (exc_ack_i) begin
			pending_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (capture) begin
			exc_action_o        <= action;
			exc_is_page_fault_o <= (except_code_i == E_INSTR_PAGE_FAULT) ||
			                       (except_code_i == E_LD_PAGE_FAULT) ||
			                       (except_code_i == E_ST_PAGE_FAULT);
			// Sv39 VPN sits above the page offset
			exc_vpn_o           <= except_tval_i[`VPN_LEN+`PAGE_OFF_LEN-1:`PAGE_OFF_LEN];
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_ctrl_fsm.sv */
// Moore outputs except stall_o, which also follows stall_req_i combinationally in every state
`timescale 1ns/1ns
`default_nettype none
`include "mem_ctl_cfg.svh"

module mem_ctrl_fsm
	import mem_ctl_pkg::*;
(
	input  wire logic             clk_i,
	input  wire logic             rst_n_i,
	input  wire logic             instr_valid_i,
	input  fence_kind_e           fence_kind_i,
	input  wire logic             stall_req_i,
	input  wire logic             exc_pending_i,
	input  exc_action_e           exc_action_i,
	input  wire logic             exc_is_page_fault_i,
	input  wire logic [`VPN_LEN-1:0] exc_vpn_i,
	input  wire logic             l2c_update_done_i,
	output logic                  idle_o,
	output logic                  exc_ack_o,
	output logic                  flush_o,
	output logic                  stall_o,
	output logic                  abort_o,
	output logic                  clr_tlb_mshr_o,
	output logic                  clr_dmshr_o,
	output logic                  synch_l1dc_l2c_o,
	output tlb_flush_e            tlb_flush_o,
	output logic [`VPN_LEN-1:0]   flush_page_o
);

	typedef enum logic [2:0] {RST_FLUSH, IDLE, FENCE_I, SYNC, SHOOTDOWN, EXCEPT} state_e;

	state_e state_q;
	state_e state_d;
	logic   sync_shootdown_q;
	logic   instr_acc;

	assign idle_o    = (state_q == IDLE);
	assign instr_acc = instr_valid_i && !stall_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q          <= RST_FLUSH;
			sync_shootdown_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// SYNC from SFENCE.VMA ends in a shootdown, from an ecall it does not
			if (state_d == SYNC && state_q != SYNC) begin
				sync_shootdown_q <= (state_q == IDLE);
			end
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			RST_FLUSH: state_d = IDLE;
			IDLE: begin
				// Exception has priority over an instruction in the same cycle
				if (exc_pending_i) begin
					state_d = EXCEPT;
				end else if (instr_acc) begin
					// Package fence kind, not the state of the same name
					if (fence_kind_i == mem_ctl_pkg::FENCE_I) begin
						state_d = FENCE_I;
					end else if (fence_kind_i == SFENCE_VMA) begin
						state_d = SYNC;
					end
				end
			end
			FENCE_I: state_d = IDLE;
			SYNC: begin
				if (l2c_update_done_i) begin
					state_d = sync_shootdown_q ? SHOOTDOWN : IDLE;
				end
			end
			SHOOTDOWN: state_d = IDLE;
			EXCEPT: state_d = (exc_action_i == ACT_ECALL) ? SYNC : IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_comb begin
		exc_ack_o        = 1'b0;
		flush_o          = 1'b0;
		stall_o          = stall_req_i;
		abort_o          = 1'b0;
		clr_tlb_mshr_o   = 1'b0;
		clr_dmshr_o      = 1'b0;
		synch_l1dc_l2c_o = 1'b0;
		tlb_flush_o      = NO_FLUSH;
		flush_page_o     = '0;

		case (state_q)
			RST_FLUSH: begin
				flush_o        = 1'b1;
				clr_tlb_mshr_o = 1'b1;
				clr_dmshr_o    = 1'b1;
				tlb_flush_o    = FLUSH_ALL;
			end
			FENCE_I: begin
				stall_o        = 1'b1;
				clr_tlb_mshr_o = 1'b1;
			end
			SYNC: begin
				stall_o          = 1'b1;
				synch_l1dc_l2c_o = 1'b1;
			end
			SHOOTDOWN: begin
				stall_o        = 1'b1;
				clr_tlb_mshr_o = 1'b1;
				clr_dmshr_o    = 1'b1;
				tlb_flush_o    = FLUSH_ALL;
			end
			EXCEPT: begin
				exc_ack_o      = 1'b1;
				flush_o        = 1'b1;
				stall_o        = 1'b1;
				clr_tlb_mshr_o = (exc_action_i == ACT_IFAULT);
				clr_dmshr_o    = (exc_action_i == ACT_DFAULT);
				abort_o        = (exc_action_i == ACT_ILLEGAL);
				if (exc_is_page_fault_i) begin
					tlb_flush_o  = FLUSH_PAGE;
					flush_page_o = exc_vpn_i;
				end
			end
			default: begin
				tlb_flush_o = NO_FLUSH;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/mem_ctl_top.sv */
// One TLB command set serves both TLB levels; ASID flushes and CSR outputs are not provided
`timescale 1ns/1ns
`default_nettype none
`include "mem_ctl_cfg.svh"

module mem_ctl_top
	import mem_ctl_pkg::*;
(
	input  wire logic               clk_i,
	input  wire logic               rst_n_i,
	input  wire logic [`ILEN-1:0]   instr_i,
	input  wire logic               instr_valid_i,
	input  wire logic               except_raised_i,
	input  except_code_e            except_code_i,
	input  wire logic [`XLEN-1:0]   except_tval_i,
	input  wire logic               stall_req_i,
	input  wire logic               l2c_update_done_i,
	output branch_type_e            branch_type_o,
	output ldst_type_e              ldst_type_o,
	output logic                    flush_o,
	output logic                    stall_o,
	output logic                    abort_o,
	output logic                    clr_tlb_mshr_o,
	output logic                    clr_dmshr_o,
	output logic                    synch_l1dc_l2c_o,
	output tlb_flush_e              tlb_flush_o,
	output logic [`VPN_LEN-1:0]     flush_page_o
);

	fence_kind_e         fence_kind;
	logic                exc_pending;
	exc_action_e         exc_action;
	logic                exc_is_page_fault;
	logic [`VPN_LEN-1:0] exc_vpn;
	logic                exc_ack;
	logic                idle;

	instr_class_decoder u_decoder (
		.instr_i       (instr_i),
		.branch_type_o (branch_type_o),
		.ldst_type_o   (ldst_type_o),
		.fence_kind_o  (fence_kind)
	);

	// Exceptions are captured only while the FSM is idle
	except_classifier u_classifier (
		.clk_i               (clk_i),
		.rst_n_i             (rst_n_i),
		.capture_en_i        (idle),
		.except_raised_i     (except_raised_i),
		.except_code_i       (except_code_i),
		.except_tval_i       (except_tval_i),
		.exc_ack_i           (exc_ack),
		.exc_pending_o       (exc_pending),
		.exc_action_o        (exc_action),
		.exc_is_page_fault_o (exc_is_page_fault),
		.exc_vpn_o           (exc_vpn)
	);

	mem_ctrl_fsm u_fsm (
		.clk_i               (clk_i),
		.rst_n_i             (rst_n_i),
		.instr_valid_i       (instr_valid_i),
		.fence_kind_i        (fence_kind),
		.stall_req_i         (stall_req_i),
		.exc_pending_i       (exc_pending),
		.exc_action_i        (exc_action),
		.exc_is_page_fault_i (exc_is_page_fault),
		.exc_vpn_i           (exc_vpn),
		.l2c_update_done_i   (l2c_update_done_i),
		.idle_o              (idle),
		.exc_ack_o           (exc_ack),
		.flush_o             (flush_o),
		.stall_o             (stall_o),
		.abort_o             (abort_o),
		.clr_tlb_mshr_o      (clr_tlb_mshr_o),
		.clr_dmshr_o         (clr_dmshr_o),
		.synch_l1dc_l2c_o    (synch_l1dc_l2c_o),
		.tlb_flush_o         (tlb_flush_o),
		.flush_page_o        (flush_page_o)
	);

endmodule

`default_nettype wire

/* testbench/tb_mem_ctl.sv */
// Needs --timing and --assert; stops at the first mismatch, and a 2000-cycle limit ends a stuck run
`timescale 1ns/1ns
`default_nettype none
`include "mem_ctl_cfg.svh"

module tb_mem_ctl
	import mem_ctl_pkg::*;
();

	localparam int MAX_CYCLES = 2000;
	localparam logic [31:0] FENCE_I_INSTR = 32'h0000100f;
	localparam logic [31:0] SFENCE_VMA_INSTR = 32'h12000073;

	logic clk_i = 1'b0;
	logic rst_n_i, instr_valid_i, except_raised_i, stall_req_i, l2c_update_done_i;
	logic [`ILEN-1:0] instr_i;
	logic [`XLEN-1:0] except_tval_i;
	except_code_e except_code_i;
	branch_type_e branch_type_o;
	ldst_type_e ldst_type_o;
	logic flush_o, stall_o, abort_o, clr_tlb_mshr_o, clr_dmshr_o, synch_l1dc_l2c_o;
	tlb_flush_e tlb_flush_o;
	logic [`VPN_LEN-1:0] flush_page_o;
	int cycle_count = 0;

	except_code_e codes[13] = '{E_I_ADDR_MISALIGNED, E_I_ACCESS_FAULT, E_ILLEGAL_INSTRUCTION,
		E_LD_ADDR_MISALIGNED, E_LD_ACCESS_FAULT, E_ST_ADDR_MISALIGNED, E_ST_ACCESS_FAULT,
		E_ENV_CALL_UMODE, E_ENV_CALL_SMODE, E_ENV_CALL_MMODE, E_INSTR_PAGE_FAULT,
		E_LD_PAGE_FAULT, E_ST_PAGE_FAULT};

	mem_ctl_top DUT (.*);

	always #20 clk_i = ~clk_i;

	task automatic end_with_failure();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped on error");
	endtask

	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: no completion within %0d cycles", MAX_CYCLES);
			end_with_failure();
		end
	end

	// Sync and back-pressure both force a stall
	stall_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(stall_req_i || synch_l1dc_l2c_o) |-> stall_o)
		else begin
			$display("[ERROR] stall_o: got 0x%0h, expected 0x1", $sampled(stall_o));
			end_with_failure();
		end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_cmds(input logic flush, input logic stall, input logic abort,
		input logic clr_t, input logic clr_d, input logic synch, input tlb_flush_e tlb,
		input logic [`VPN_LEN-1:0] page);
		check_val("flush_o", flush_o, flush);
		check_val("stall_o", stall_o, stall);
		check_val("abort_o", abort_o, abort);
		check_val("clr_tlb_mshr_o", clr_tlb_mshr_o, clr_t);
		check_val("clr_dmshr_o", clr_dmshr_o, clr_d);
		check_val("synch_l1dc_l2c_o", synch_l1dc_l2c_o, synch);
		check_val("tlb_flush_o", tlb_flush_o, tlb);
		check_val("flush_page_o", flush_page_o, page);
	endtask

	// Class tables straight from the ISA encodings
	function automatic branch_type_e exp_branch(input logic [6:0] opc, input logic [2:0] f3);
		if (opc != 7'b1100011) return beq;
		case (f3)
			3'b001: return bne;
			3'b100: return blt;
			3'b101: return bge;
			3'b110: return bltu;
			3'b111: return bgeu;
			default: return beq;
		endcase
	endfunction

	function automatic ldst_type_e exp_ldst(input logic [6:0] opc, input logic [2:0] f3);
		if (opc == 7'b0000011) begin
			case (f3)
				3'b000: return LS_BYTE;
				3'b001: return LS_HALFWORD;
				3'b011: return LS_DOUBLEWORD;
				3'b100: return LS_BYTE_U;
				3'b101: return LS_HALFWORD_U;
				3'b110: return LS_WORD_U;
				default: return LS_WORD;
			endcase
		end
		if (opc == 7'b0100011 && f3 == 3'b000) return LS_BYTE;
		if (opc == 7'b0100011 && f3 == 3'b001) return LS_HALFWORD;
		if (opc == 7'b0100011 && f3 == 3'b011) return LS_DOUBLEWORD;
		return LS_WORD;
	endfunction

	function automatic exc_action_e exp_action(input logic [3:0] code);
		case (code)
			4'd0, 4'd1, 4'd12: return ACT_IFAULT;
			4'd4, 4'd5, 4'd6, 4'd7, 4'd13, 4'd15: return ACT_DFAULT;
			4'd2: return ACT_ILLEGAL;
			4'd9, 4'd11: return ACT_ECALL;
			default: return ACT_NONE;
		endcase
	endfunction

	// Holds until the instruction is taken at an edge with stall_o low
	task automatic issue_instr(input logic [31:0] instr);
		logic accepted;
		@(posedge clk_i);
		instr_i <= instr;
		instr_valid_i <= 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk_i);
			accepted = !stall_o;
			@(posedge clk_i);
		end
		instr_valid_i <= 1'b0;
	endtask

	// L2 side of the sync handshake, done after a random delay
	task automatic complete_l2_sync();
		int delay;
		int hold;
		delay = 1 + ($urandom % 8);
		repeat (delay) begin
			@(negedge clk_i);
			check_val("synch_l1dc_l2c_o", synch_l1dc_l2c_o, 1);
		end
		@(posedge clk_i);
		l2c_update_done_i <= 1'b1;
		hold = 0;
		@(negedge clk_i);
		while (synch_l1dc_l2c_o) begin
			hold++;
			@(posedge clk_i);
			l2c_update_done_i <= 1'b0;
			@(negedge clk_i);
		end
		check_val("synch hold after done", hold, 1);
	endtask

	task automatic run_exception(input except_code_e code, input logic [63:0] tval);
		exc_action_e act;
		logic pf;
		act = exp_action(code);
		pf = (code == 4'd12) || (code == 4'd13) || (code == 4'd15);
		@(posedge clk_i);
		except_raised_i <= 1'b1;
		except_code_i <= code;
		except_tval_i <= tval;
		@(posedge clk_i);
		except_raised_i <= 1'b0;
		@(negedge clk_i);
		check_cmds(1, 1, act == ACT_ILLEGAL, act == ACT_IFAULT, act == ACT_DFAULT, 0,
			pf ? FLUSH_PAGE : NO_FLUSH, pf ? tval[38:12] : '0);
		if (act == ACT_ECALL) complete_l2_sync();
		else @(negedge clk_i);
		check_cmds(0, 0, 0, 0, 0, 0, NO_FLUSH, '0);
	endtask

	initial begin
		logic [31:0] instr;
		logic [6:0] opc;
		void'($urandom(32'hcef0));
		rst_n_i = 1'b0;
		instr_valid_i = 1'b0;
		except_raised_i = 1'b0;
		stall_req_i = 1'b0;
		l2c_update_done_i = 1'b0;
		instr_i = '0;
		except_tval_i = '0;
		except_code_i = E_I_ADDR_MISALIGNED;
		repeat (2) begin
			@(negedge clk_i);
			check_cmds(1, 0, 0, 1, 1, 0, FLUSH_ALL, '0);
			@(posedge clk_i);
		end
		rst_n_i <= 1'b1;
		@(negedge clk_i);
		@(negedge clk_i);
		check_cmds(0, 0, 0, 0, 0, 0, NO_FLUSH, '0);

		// Decode with valid low so nothing is issued
		repeat (24) begin
			case ($urandom % 4)
				0: opc = 7'b1100011;
				1: opc = 7'b0000011;
				2: opc = 7'b0100011;
				default: opc = 7'b0110011;
			endcase
			instr = $urandom;
			instr[6:0] = opc;
			@(posedge clk_i);
			instr_i <= instr;
			@(negedge clk_i);
			check_val("branch_type_o", branch_type_o, exp_branch(opc, instr[14:12]));
			check_val("ldst_type_o", ldst_type_o, exp_ldst(opc, instr[14:12]));
		end

		issue_instr(FENCE_I_INSTR);
		@(negedge clk_i);
		check_cmds(0, 1, 0, 1, 0, 0, NO_FLUSH, '0);
		@(negedge clk_i);
		check_cmds(0, 0, 0, 0, 0, 0, NO_FLUSH, '0);

		repeat (4) begin
			issue_instr(SFENCE_VMA_INSTR);
			complete_l2_sync();
			check_cmds(0, 1, 0, 1, 1, 0, FLUSH_ALL, '0);
			@(negedge clk_i);
			check_cmds(0, 0, 0, 0, 0, 0, NO_FLUSH, '0);
		end

		run_exception(E_LD_PAGE_FAULT, 64'h0000_0045_6789_a123);
		run_exception(E_ENV_CALL_SMODE, 64'h0);
		run_exception(E_ILLEGAL_INSTRUCTION, 64'h0);
		repeat (30) begin
			run_exception(codes[$urandom % 13], {$urandom, $urandom});
		end

		// FENCE.I held back while the main control stalls
		@(posedge clk_i);
		stall_req_i <= 1'b1;
		instr_i <= FENCE_I_INSTR;
		instr_valid_i <= 1'b1;
		repeat (3) begin
			@(negedge clk_i);
			check_cmds(0, 1, 0, 0, 0, 0, NO_FLUSH, '0);
		end
		@(posedge clk_i);
		stall_req_i <= 1'b0;
		@(posedge clk_i);
		instr_valid_i <= 1'b0;
		@(negedge clk_i);
		check_cmds(0, 1, 0, 1, 0, 0, NO_FLUSH, '0);
		@(negedge clk_i);
		check_cmds(0, 0, 0, 0, 0, 0, NO_FLUSH, '0);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/mem_ctl_pkg.sv
hdl/instr_class_decoder.sv
hdl/except_classifier.sv
hdl/mem_ctrl_fsm.sv
hdl/mem_ctl_top.sv
testbench/tb_mem_ctl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, then checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_ctl \
	-f sources.f \
	-o sim_tb

# The simulator's exit status is not used, the log decides
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi
echo "Simulation passed"
